/* integerDct8x8.f */
+incdir+verilog
+incdir+tb
verilog/dctPkg.sv
verilog/signPatternTransform.sv
verilog/columnPass.sv
verilog/rowPass.sv
verilog/integerDct8x8.sv
tb/tbIntegerDct8x8.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the 8x8 transform testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f integerDct8x8.f --top-module tbIntegerDct8x8 -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }

simOut="$(./obj_dir/VtbIntegerDct8x8 2>&1)"
echo "$simOut"

echo "$simOut" | grep -qx "test passed" && exit 0 || exit 1

/* tb/dctRefModel.svh */
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

////////////////////
// Sign patterns
////////////////////

// Weight (+1, 0 or -1) of entry k in pattern u
function automatic int patternWeight(input int u, input int k);
    int weight;
    weight = 0;
    case (u)
        0: weight = 1;
        1: weight = (k == 1) ? 1 : ((k == 6) ? -1 : 0);
        2:
        begin
            if (k inside {0, 7})
                weight = 1;
            else if (k inside {3, 4})
                weight = -1;
        end
        3: weight = (k == 0) ? 1 : ((k == 7) ? -1 : 0);
        4: weight = (k inside {0, 3, 4, 7}) ? 1 : -1;
        5: weight = (k == 3) ? 1 : ((k == 4) ? -1 : 0);
        6:
        begin
            if (k inside {2, 5})
                weight = 1;
            else if (k inside {1, 6})
                weight = -1;
        end
        7: weight = (k == 2) ? 1 : ((k == 5) ? -1 : 0);
        default: weight = 0;
    endcase
    return weight;
endfunction

////////////////////
// Full 2-D transform
////////////////////

// Expected coefficients for one pixel block, kept in full integer range
function automatic coefBlock_t dctRef(input pixelBlock_t blk);
    int midVal [`DCT_N][`DCT_N];
    int acc;
    coefBlock_t result;
    // Down every column, rows 0 to 7
    for (int u = 0; u < `DCT_N; u++)
    begin
        for (int c = 0; c < `DCT_N; c++)
        begin
            acc = 0;
            for (int r = 0; r < `DCT_N; r++)
                acc += patternWeight(u, r) * int'(blk[r][c]);
            midVal[u][c] = acc;
        end
    end
    // Across every row of column results
    for (int u = 0; u < `DCT_N; u++)
    begin
        for (int v = 0; v < `DCT_N; v++)
        begin
            acc = 0;
            for (int c = 0; c < `DCT_N; c++)
                acc += patternWeight(v, c) * midVal[u][c];
            result[u][v] = coef_t'(acc);
        end
    end
    return result;
endfunction

`endif

/* tb/tbIntegerDct8x8.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dctParams.svh"

module tbIntegerDct8x8
    import dctPkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int unsigned RNG_SEED = 32'h71f9_085e;

    localparam int FLAT_COUNT    = 6;
    localparam int IMPULSE_COUNT = `DCT_N * `DCT_N;
    localparam int EXTREME_COUNT = 6;
    localparam int RANDOM_COUNT  = 200;
    localparam int NUM_BLOCKS    = FLAT_COUNT + IMPULSE_COUNT + EXTREME_COUNT + RANDOM_COUNT;
    localparam int TIMEOUT_NS    = (RESET_CYCLES + NUM_BLOCKS + 20) * CLK_PERIOD;

    localparam pixel_t FLAT_VALUES [FLAT_COUNT] = '{8'd0, 8'd1, 8'd37, 8'd128, 8'd200, 8'd255};

    logic        clk;
    logic        arstN;
    pixelBlock_t pixels;
    coefBlock_t  coef;

    // Expected results in the order the blocks were applied
    coefBlock_t expQ [$];

    `include "dctRefModel.svh"

    integerDct8x8 i_dut (
        .i_clk    (clk),
        .i_arstN  (arstN),
        .i_pixels (pixels),
        .o_coef   (coef)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Block builders
    ////////////////////

    function automatic pixelBlock_t flatBlock(input pixel_t value);
        pixelBlock_t blk;
        for (int r = 0; r < `DCT_N; r++)
            for (int c = 0; c < `DCT_N; c++)
                blk[r][c] = value;
        return blk;
    endfunction

    function automatic pixelBlock_t impulseBlock(input int row, input int col);
        pixelBlock_t blk;
        blk = '0;
        blk[row][col] = 8'd255;
        return blk;
    endfunction

    // Kind 0 checkerboard, 1 row stripes, 2 column stripes
    function automatic pixelBlock_t extremeBlock(input int kind, input int phase);
        pixelBlock_t blk;
        int sel;
        for (int r = 0; r < `DCT_N; r++)
        begin
            for (int c = 0; c < `DCT_N; c++)
            begin
                sel = (kind == 0) ? (r + c) : ((kind == 1) ? r : c);
                blk[r][c] = ((sel % 2) == phase) ? 8'd255 : 8'd0;
            end
        end
        return blk;
    endfunction

    function automatic pixelBlock_t randomBlock();
        pixelBlock_t blk;
        for (int r = 0; r < `DCT_N; r++)
            for (int c = 0; c < `DCT_N; c++)
                blk[r][c] = pixel_t'($urandom());
        return blk;
    endfunction

    ////////////////////
    // Drive and compare
    ////////////////////

    // Called on a falling edge, returns on the next one
    task automatic applyBlock(input pixelBlock_t blk);
        pixels = blk;
        expQ.push_back(dctRef(blk));
        @(negedge clk);
    endtask

    task automatic compareCoef(input string name, input coef_t expected, input coef_t actual);
        if (actual !== expected)
        begin
            $display("Error at %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "Simulation stopped at the first mismatch");
        end
    endtask

    task automatic checkBlock(input coefBlock_t expected, input string tag);
        for (int u = 0; u < `DCT_N; u++)
            for (int v = 0; v < `DCT_N; v++)
                compareCoef($sformatf("o_coef[%0d][%0d] (%s)", u, v, tag),
                            expected[u][v], coef[u][v]);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial
    begin : driveStimulus
        clk = 1'b0;
        arstN = 1'b1;
        void'($urandom(RNG_SEED));
        pixels = randomBlock();
        // Falling edge of reset after time zero so the registers see it
        #1;
        arstN = 1'b0;
        repeat (RESET_CYCLES - 1)
        begin
            @(negedge clk);
            pixels = randomBlock();
        end
        @(negedge clk);
        arstN = 1'b1;

        for (int i = 0; i < FLAT_COUNT; i++)
            applyBlock(flatBlock(FLAT_VALUES[i]));

        // One impulse per position, row-major
        for (int r = 0; r < `DCT_N; r++)
            for (int c = 0; c < `DCT_N; c++)
                applyBlock(impulseBlock(r, c));

        for (int kind = 0; kind < 3; kind++)
            for (int phase = 0; phase < 2; phase++)
                applyBlock(extremeBlock(kind, phase));

        // Back-to-back random blocks, two in flight at once
        repeat (RANDOM_COUNT)
            applyBlock(randomBlock());
    end

    ////////////////////
    // Checker
    ////////////////////

    initial
    begin : checkResults
        coefBlock_t expected;
        wait (arstN === 1'b0);
        while (arstN === 1'b0)
        begin
            @(posedge clk or posedge arstN);
            #1;
            if (arstN === 1'b0)
                checkBlock('0, "during reset");
        end
        // First block is sampled here, its result follows one edge later
        @(posedge clk);
        for (int k = 0; k < NUM_BLOCKS; k++)
        begin
            @(posedge clk);
            #1;
            if (expQ.size() == 0)
            begin
                $display("No expected result was queued when block %0d came out", k);
                $display("test failed");
                $fatal(1, "Simulation stopped on an empty expected-value queue");
            end
            else
            begin
                expected = expQ.pop_front();
                checkBlock(expected, $sformatf("block %0d", k));
            end
        end
        $display("test passed");
        $finish;
    end

    // Watchdog
    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns before all blocks were checked", TIMEOUT_NS);
        $display("test failed");
        $fatal(1, "Simulation stopped by the watchdog");
    end

endmodule

`default_nettype wire

/* verilog/columnPass.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dctParams.svh"

module columnPass
    import dctPkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_arstN,
    input  wire pixelBlock_t i_pixels,
    output midBlock_t        o_mid
);

    // Pixel widened by one bit so the transform sees it as positive
    localparam int COL_IN_W = `DCT_PIXEL_W + 1;

    // Column c, row r
    logic signed [COL_IN_W-1:0] colVec [`DCT_N][`DCT_N];

    // Column c, pattern u
    logic signed [`DCT_MID_W-1:0] colRes [`DCT_N][`DCT_N];

    // Results rearranged into block order
    midBlock_t midNext;

    // Stage register
    midBlock_t midQ;

    ////////////////////
    // Gather columns
    ////////////////////

    genvar c;
    genvar r;
    genvar u;
    generate
        for (c = 0; c < `DCT_N; c++)
        begin : genColumn
            for (r = 0; r < `DCT_N; r++)
            begin : genGather
                assign colVec[c][r] = {1'b0, i_pixels[r][c]};
            end

            // One transform per column
            signPatternTransform #(
                .IN_W  (COL_IN_W),
                .OUT_W (`DCT_MID_W)
            ) colXfm (
                .i_vec (colVec[c]),
                .o_vec (colRes[c])
            );

            ////////////////////
            // Scatter results
            ////////////////////

            // Pattern u of column c lands in row u of the block
            for (u = 0; u < `DCT_N; u++)
            begin : genScatter
                assign midNext[u][c] = colRes[c][u];
            end
        end
    endgenerate

    ////////////////////
    // Pipeline register
    ////////////////////

    always_ff @(posedge i_clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            midQ <= '0;
        end
        else
        begin
            midQ <= midNext;
        end
    end

    // Held for one cycle while the row pass works on it
    assign o_mid = midQ;

endmodule

`default_nettype wire

/* verilog/dctParams.svh */
`ifndef DCT_PARAMS_SVH
`define DCT_PARAMS_SVH

////////////////////
// Block geometry
////////////////////

// Points per dimension
`define DCT_N 8

////////////////////
// Data widths
////////////////////

// Unsigned input pixel
`define DCT_PIXEL_W 8

// Column result, holds 8 x 255 in either sign
`define DCT_MID_W 12

// Coefficient, holds 8 x largest column result
`define DCT_COEF_W 16

`endif

/* verilog/dctPkg.sv */
`default_nettype none

`include "dctParams.svh"

package dctPkg;

    ////////////////////
    // Element types
    ////////////////////

    // Raw pixel, always positive
    typedef logic [`DCT_PIXEL_W-1:0] pixel_t;

    // Output of the column pass
    typedef logic signed [`DCT_MID_W-1:0] mid_t;

    // Final transform coefficient
    typedef logic signed [`DCT_COEF_W-1:0] coef_t;

    ////////////////////
    // Block types
    ////////////////////

    // [row][column]
    typedef pixel_t [`DCT_N-1:0][`DCT_N-1:0] pixelBlock_t;

    // [vertical frequency][column]
    typedef mid_t [`DCT_N-1:0][`DCT_N-1:0] midBlock_t;

    // [vertical frequency][horizontal frequency]
    typedef coef_t [`DCT_N-1:0][`DCT_N-1:0] coefBlock_t;

endpackage

`default_nettype wire

/* verilog/integerDct8x8.sv */
`timescale 1ns/1ps
`default_nettype none

module integerDct8x8
    import dctPkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_arstN,
    input  wire pixelBlock_t i_pixels,
    output coefBlock_t       o_coef
);

    // Column results between the two register stages
    midBlock_t mid;

    ////////////////////
    // Stage 1
    ////////////////////

    // Vertical patterns down every column
    columnPass colPass (
        .i_clk    (i_clk),
        .i_arstN  (i_arstN),
        .i_pixels (i_pixels),
        .o_mid    (mid)
    );

    ////////////////////
    // Stage 2
    ////////////////////

    // Horizontal patterns across every row of results,
    // coefficients valid two edges after the pixels are sampled
    rowPass rowPassInst (
        .i_clk   (i_clk),
        .i_arstN (i_arstN),
        .i_mid   (mid),
        .o_coef  (o_coef)
    );

endmodule

`default_nettype wire

/* verilog/rowPass.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dctParams.svh"

module rowPass
    import dctPkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_arstN,
    input  wire midBlock_t i_mid,
    output coefBlock_t     o_coef
);

    // Row u, column c of the intermediate block
    logic signed [`DCT_MID_W-1:0] rowVec [`DCT_N][`DCT_N];

    // Row u, pattern v
    logic signed [`DCT_COEF_W-1:0] rowRes [`DCT_N][`DCT_N];

    // Coefficients in block order
    coefBlock_t coefNext;

    // Output register
    coefBlock_t coefQ;

    ////////////////////
    // Row transforms
    ////////////////////

    genvar u;
    genvar c;
    genvar v;
    generate
        for (u = 0; u < `DCT_N; u++)
        begin : genRow
            // Row u taken from column 0 to column 7
            for (c = 0; c < `DCT_N; c++)
            begin : genGather
                assign rowVec[u][c] = i_mid[u][c];
            end

            signPatternTransform #(
                .IN_W  (`DCT_MID_W),
                .OUT_W (`DCT_COEF_W)
            ) rowXfm (
                .i_vec (rowVec[u]),
                .o_vec (rowRes[u])
            );

            // Each coefficient stays in its own row
            for (v = 0; v < `DCT_N; v++)
            begin : genPlace
                assign coefNext[u][v] = rowRes[u][v];
            end
        end
    endgenerate

    ////////////////////
    // Pipeline register
    ////////////////////

    always_ff @(posedge i_clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            coefQ <= '0;
        end
        else
        begin
            coefQ <= coefNext;
        end
    end

    assign o_coef = coefQ;

endmodule

`default_nettype wire

/* verilog/signPatternTransform.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dctParams.svh"

module signPatternTransform #(
    parameter int IN_W  = 9,
    parameter int OUT_W = 12
)
(
    input  wire logic signed [IN_W-1:0]  i_vec [`DCT_N],
    output logic signed      [OUT_W-1:0] o_vec [`DCT_N]
);

    // Inputs widened to the output width
    logic signed [OUT_W-1:0] x [`DCT_N];

    // Mirror pair sums
    logic signed [OUT_W-1:0] sum07;
    logic signed [OUT_W-1:0] sum16;
    logic signed [OUT_W-1:0] sum25;
    logic signed [OUT_W-1:0] sum34;

    // Mirror pair differences
    logic signed [OUT_W-1:0] dif07;
    logic signed [OUT_W-1:0] dif16;
    logic signed [OUT_W-1:0] dif25;
    logic signed [OUT_W-1:0] dif34;

    ////////////////////
    // Sign extension
    ////////////////////

    genvar k;
    generate
        for (k = 0; k < `DCT_N; k++)
        begin : genExtend
            assign x[k] = OUT_W'(i_vec[k]);
        end
    endgenerate

    ////////////////////
    // Butterfly
    ////////////////////

    // Every pattern is symmetric or antisymmetric about the middle,
    // so each output only needs the pair sums or the pair differences
    always_comb
    begin
        sum07 = x[0] + x[7];
        sum16 = x[1] + x[6];
        sum25 = x[2] + x[5];
        sum34 = x[3] + x[4];

        dif07 = x[0] - x[7];
        dif16 = x[1] - x[6];
        dif25 = x[2] - x[5];
        dif34 = x[3] - x[4];
    end

    ////////////////////
    // Pattern outputs
    ////////////////////

    always_comb
    begin
        // Even patterns from the sums
        o_vec[0] = sum07 + sum16 + sum25 + sum34;
        o_vec[2] = sum07 - sum34;
        o_vec[4] = sum07 + sum34 - sum16 - sum25;
        o_vec[6] = sum25 - sum16;

        // Odd patterns are single differences
        o_vec[1] = dif16;
        o_vec[3] = dif07;
        o_vec[5] = dif34;
        o_vec[7] = dif25;
    end

endmodule

`default_nettype wire
